//--- verilog/tlb_config.svh
`ifndef TLB_CONFIG_SVH
`define TLB_CONFIG_SVH

// ------------------------------
// table size
// ------------------------------

// entry count, index width follows from it
`define TLB_NUM 16

// ------------------------------
// page size codes
// ------------------------------

`define TLB_PS_4K 12 // 4 KB page
`define TLB_PS_2M 21 // 2 MB page

`endif

//--- verilog/tlb_pkg.sv
`default_nettype none

`include "tlb_config.svh"

package tlb_pkg;

    // index and per-entry flags
    typedef logic [$clog2(`TLB_NUM)-1:0] tlb_index_t;
    typedef logic [`TLB_NUM-1:0]         tlb_vec_t;

    // virtual side
    typedef logic [18:0] vppn_t;  // va[31:13]
    typedef logic [9:0]  asid_t;
    typedef logic [5:0]  ps_t;

    // physical side
    typedef logic [19:0] ppn_t;
    typedef logic [1:0]  plv_t;
    typedef logic [1:0]  mat_t;

    typedef logic [4:0]  invtlb_op_t;

    // vppn bits below this one are don't-care for a 2 MB page
    localparam int unsigned HUGE_LOW_BITS = `TLB_PS_2M - `TLB_PS_4K;

endpackage

`default_nettype wire

//--- verilog/tlb_entry_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_config.svh"

module tlb_entry_array (
    input  wire                      clk,
    input  wire                      rst,
    // write port
    input  wire                      we,
    input  wire tlb_pkg::tlb_index_t w_index,
    input  wire                      w_e,
    input  wire                      w_g,
    input  wire tlb_pkg::vppn_t      w_vppn,
    input  wire tlb_pkg::ps_t        w_ps,
    input  wire tlb_pkg::asid_t      w_asid,
    input  wire tlb_pkg::ppn_t       w_ppn0,
    input  wire tlb_pkg::ppn_t       w_ppn1,
    input  wire tlb_pkg::plv_t       w_plv0,
    input  wire tlb_pkg::plv_t       w_plv1,
    input  wire tlb_pkg::mat_t       w_mat0,
    input  wire tlb_pkg::mat_t       w_mat1,
    input  wire                      w_d0,
    input  wire                      w_d1,
    input  wire                      w_v0,
    input  wire                      w_v1,
    // invalidate
    input  wire                      invtlb_valid,
    input  wire tlb_pkg::tlb_vec_t   inv_vec,
    // read port
    input  wire tlb_pkg::tlb_index_t r_index,
    output logic                     r_e,
    output tlb_pkg::vppn_t           r_vppn,
    output tlb_pkg::ps_t             r_ps,
    output tlb_pkg::asid_t           r_asid,
    output logic                     r_g,
    output tlb_pkg::ppn_t            r_ppn0,
    output tlb_pkg::plv_t            r_plv0,
    output tlb_pkg::mat_t            r_mat0,
    output logic                     r_d0,
    output logic                     r_v0,
    output tlb_pkg::ppn_t            r_ppn1,
    output tlb_pkg::plv_t            r_plv1,
    output tlb_pkg::mat_t            r_mat1,
    output logic                     r_d1,
    output logic                     r_v1,
    // stored table, seen by match and search
    output tlb_pkg::tlb_vec_t        ent_e,
    output tlb_pkg::tlb_vec_t        ent_g,
    output tlb_pkg::vppn_t           ent_vppn [`TLB_NUM],
    output tlb_pkg::ps_t             ent_ps   [`TLB_NUM],
    output tlb_pkg::asid_t           ent_asid [`TLB_NUM],
    output tlb_pkg::ppn_t            ent_ppn0 [`TLB_NUM],
    output tlb_pkg::ppn_t            ent_ppn1 [`TLB_NUM],
    output tlb_pkg::plv_t            ent_plv0 [`TLB_NUM],
    output tlb_pkg::plv_t            ent_plv1 [`TLB_NUM],
    output tlb_pkg::mat_t            ent_mat0 [`TLB_NUM],
    output tlb_pkg::mat_t            ent_mat1 [`TLB_NUM],
    output logic                     ent_d0   [`TLB_NUM],
    output logic                     ent_d1   [`TLB_NUM],
    output logic                     ent_v0   [`TLB_NUM],
    output logic                     ent_v1   [`TLB_NUM]
);

    // ------------------------------
    // valid bits
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ent_e <= '0;
        end else begin
            if (invtlb_valid) begin
                ent_e <= ent_e & ~inv_vec;
            end
            if (we) begin
                ent_e[w_index] <= w_e; // later assignment, so write wins
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (we) begin
            ent_g[w_index]    <= w_g;
            ent_vppn[w_index] <= w_vppn;
            ent_ps[w_index]   <= w_ps;
            ent_asid[w_index] <= w_asid;
            ent_ppn0[w_index] <= w_ppn0;
            ent_plv0[w_index] <= w_plv0;
            ent_mat0[w_index] <= w_mat0;
            ent_d0[w_index]   <= w_d0;
            ent_v0[w_index]   <= w_v0;
            ent_ppn1[w_index] <= w_ppn1;
            ent_plv1[w_index] <= w_plv1;
            ent_mat1[w_index] <= w_mat1;
            ent_d1[w_index]   <= w_d1;
            ent_v1[w_index]   <= w_v1;
        end
    end

    // ------------------------------
    // read port, one cycle
    // ------------------------------
    always_ff @(posedge clk) begin
        r_e    <= ent_e[r_index];
        r_g    <= ent_g[r_index];
        r_vppn <= ent_vppn[r_index];
        r_ps   <= ent_ps[r_index];
        r_asid <= ent_asid[r_index];
        r_ppn0 <= ent_ppn0[r_index];
        r_plv0 <= ent_plv0[r_index];
        r_mat0 <= ent_mat0[r_index];
        r_d0   <= ent_d0[r_index];
        r_v0   <= ent_v0[r_index];
        r_ppn1 <= ent_ppn1[r_index];
        r_plv1 <= ent_plv1[r_index];
        r_mat1 <= ent_mat1[r_index];
        r_d1   <= ent_d1[r_index];
        r_v1   <= ent_v1[r_index];
    end

endmodule

`default_nettype wire

//--- verilog/tlb_match.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_config.svh"

module tlb_match (
    input  wire tlb_pkg::vppn_t      s_vppn,
    input  wire tlb_pkg::asid_t      s_asid,
    input  wire tlb_pkg::invtlb_op_t invtlb_op,
    input  wire tlb_pkg::tlb_vec_t   ent_e,
    input  wire tlb_pkg::tlb_vec_t   ent_g,
    input  wire tlb_pkg::vppn_t      ent_vppn [`TLB_NUM],
    input  wire tlb_pkg::ps_t        ent_ps   [`TLB_NUM],
    input  wire tlb_pkg::asid_t      ent_asid [`TLB_NUM],
    output tlb_pkg::tlb_vec_t        hit_vec,
    output tlb_pkg::tlb_vec_t        inv_vec
);
    import tlb_pkg::*;

    // high vppn bits only, for 2 MB pages
    localparam vppn_t HUGE_MASK = {{($bits(vppn_t) - HUGE_LOW_BITS){1'b1}},
                                   {HUGE_LOW_BITS{1'b0}}};

    tlb_vec_t asid_hit;
    tlb_vec_t vppn_hit;

    // ------------------------------
    // per-entry compare
    // ------------------------------
    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            asid_hit[i] = (ent_asid[i] == s_asid);
            if (ent_ps[i] == ps_t'(`TLB_PS_2M)) begin
                vppn_hit[i] = ((ent_vppn[i] ^ s_vppn) & HUGE_MASK) == '0;
            end else begin
                vppn_hit[i] = (ent_vppn[i] == s_vppn);
            end
        end
    end

    // global entries ignore asid
    assign hit_vec = ent_e & (asid_hit | ent_g) & vppn_hit;

    // ------------------------------
    // invtlb select
    // ------------------------------
    always_comb begin
        case (invtlb_op)
            5'd0, 5'd1: inv_vec = '1;
            5'd2:       inv_vec = ent_g;
            5'd3:       inv_vec = ~ent_g;
            5'd4:       inv_vec = ~ent_g & asid_hit;
            5'd5:       inv_vec = ~ent_g & asid_hit & vppn_hit;
            5'd6:       inv_vec = (ent_g | asid_hit) & vppn_hit;
            default:    inv_vec = '0; // reserved op, no effect
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/tlb_search_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_config.svh"

module tlb_search_stage (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    s_valid,
    input  wire                    s_va_bit12,
    input  wire tlb_pkg::vppn_t    s_vppn,
    input  wire tlb_pkg::tlb_vec_t hit_vec,
    input  wire tlb_pkg::ps_t      ent_ps   [`TLB_NUM],
    input  wire tlb_pkg::ppn_t     ent_ppn0 [`TLB_NUM],
    input  wire tlb_pkg::ppn_t     ent_ppn1 [`TLB_NUM],
    input  wire tlb_pkg::plv_t     ent_plv0 [`TLB_NUM],
    input  wire tlb_pkg::plv_t     ent_plv1 [`TLB_NUM],
    input  wire tlb_pkg::mat_t     ent_mat0 [`TLB_NUM],
    input  wire tlb_pkg::mat_t     ent_mat1 [`TLB_NUM],
    input  wire                    ent_d0   [`TLB_NUM],
    input  wire                    ent_d1   [`TLB_NUM],
    input  wire                    ent_v0   [`TLB_NUM],
    input  wire                    ent_v1   [`TLB_NUM],
    output logic                   s_resp_valid,
    output logic                   s_found,
    output tlb_pkg::tlb_index_t    s_index,
    output tlb_pkg::ppn_t          s_ppn,
    output tlb_pkg::ps_t           s_ps,
    output tlb_pkg::plv_t          s_plv,
    output tlb_pkg::mat_t          s_mat,
    output logic                   s_d,
    output logic                   s_v
);
    import tlb_pkg::*;

    tlb_index_t hit_idx;
    logic       odd;
    logic       take;

    // lowest index wins
    always_comb begin
        hit_idx = '0;
        for (int i = `TLB_NUM - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_idx = tlb_index_t'(i);
            end
        end
    end

    assign odd  = (ent_ps[hit_idx] == ps_t'(`TLB_PS_2M)) ? s_vppn[HUGE_LOW_BITS-1] : s_va_bit12;
    assign take = s_valid && (|hit_vec);

    // ------------------------------
    // response register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            s_resp_valid <= 1'b0;
            s_found      <= 1'b0;
        end else begin
            s_resp_valid <= s_valid;
            s_found      <= take;
        end
    end

    always_ff @(posedge clk) begin
        s_index <= take ? hit_idx : '0;
        s_ps    <= take ? ent_ps[hit_idx] : '0;
        if (!take) begin  // miss or idle
            s_ppn <= '0;
            s_plv <= '0;
            s_mat <= '0;
            s_d   <= 1'b0;
            s_v   <= 1'b0;
        end else if (odd) begin
            s_ppn <= ent_ppn1[hit_idx];
            s_plv <= ent_plv1[hit_idx];
            s_mat <= ent_mat1[hit_idx];
            s_d   <= ent_d1[hit_idx];
            s_v   <= ent_v1[hit_idx];
        end else begin
            s_ppn <= ent_ppn0[hit_idx];
            s_plv <= ent_plv0[hit_idx];
            s_mat <= ent_mat0[hit_idx];
            s_d   <= ent_d0[hit_idx];
            s_v   <= ent_v0[hit_idx];
        end
    end

endmodule

`default_nettype wire

//--- verilog/tlb_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_config.svh"

module tlb_unit (
    input  wire                      clk,
    input  wire                      rst,
    // search
    input  wire                      s_valid,
    input  wire tlb_pkg::vppn_t      s_vppn,
    input  wire                      s_va_bit12,
    input  wire tlb_pkg::asid_t      s_asid,
    output wire                      s_resp_valid,
    output wire                      s_found,
    output wire tlb_pkg::tlb_index_t s_index,
    output wire tlb_pkg::ppn_t       s_ppn,
    output wire tlb_pkg::ps_t        s_ps,
    output wire tlb_pkg::plv_t       s_plv,
    output wire tlb_pkg::mat_t       s_mat,
    output wire                      s_d,
    output wire                      s_v,
    // invalidate, asid and vppn come from the search inputs
    input  wire                      invtlb_valid,
    input  wire tlb_pkg::invtlb_op_t invtlb_op,
    // write
    input  wire                      we,
    input  wire tlb_pkg::tlb_index_t w_index,
    input  wire                      w_e,
    input  wire tlb_pkg::vppn_t      w_vppn,
    input  wire tlb_pkg::ps_t        w_ps,
    input  wire tlb_pkg::asid_t      w_asid,
    input  wire                      w_g,
    input  wire tlb_pkg::ppn_t       w_ppn0,
    input  wire tlb_pkg::plv_t       w_plv0,
    input  wire tlb_pkg::mat_t       w_mat0,
    input  wire                      w_d0,
    input  wire                      w_v0,
    input  wire tlb_pkg::ppn_t       w_ppn1,
    input  wire tlb_pkg::plv_t       w_plv1,
    input  wire tlb_pkg::mat_t       w_mat1,
    input  wire                      w_d1,
    input  wire                      w_v1,
    // read
    input  wire tlb_pkg::tlb_index_t r_index,
    output wire                      r_e,
    output wire tlb_pkg::vppn_t      r_vppn,
    output wire tlb_pkg::ps_t        r_ps,
    output wire tlb_pkg::asid_t      r_asid,
    output wire                      r_g,
    output wire tlb_pkg::ppn_t       r_ppn0,
    output wire tlb_pkg::plv_t       r_plv0,
    output wire tlb_pkg::mat_t       r_mat0,
    output wire                      r_d0,
    output wire                      r_v0,
    output wire tlb_pkg::ppn_t       r_ppn1,
    output wire tlb_pkg::plv_t       r_plv1,
    output wire tlb_pkg::mat_t       r_mat1,
    output wire                      r_d1,
    output wire                      r_v1
);
    import tlb_pkg::*;

    // ------------------------------
    // stored table and match vectors
    // ------------------------------
    wire tlb_vec_t ent_e;
    wire tlb_vec_t ent_g;
    wire vppn_t    ent_vppn [`TLB_NUM];
    wire ps_t      ent_ps   [`TLB_NUM];
    wire asid_t    ent_asid [`TLB_NUM];
    wire ppn_t     ent_ppn0 [`TLB_NUM];
    wire ppn_t     ent_ppn1 [`TLB_NUM];
    wire plv_t     ent_plv0 [`TLB_NUM];
    wire plv_t     ent_plv1 [`TLB_NUM];
    wire mat_t     ent_mat0 [`TLB_NUM];
    wire mat_t     ent_mat1 [`TLB_NUM];
    wire           ent_d0   [`TLB_NUM];
    wire           ent_d1   [`TLB_NUM];
    wire           ent_v0   [`TLB_NUM];
    wire           ent_v1   [`TLB_NUM];
    wire tlb_vec_t hit_vec;
    wire tlb_vec_t inv_vec;

    // port names line up with the wires above
    tlb_entry_array u_entry_array (.*);

    tlb_match u_match (.*);

    tlb_search_stage u_search_stage (.*);

endmodule

`default_nettype wire

//--- test/tlb_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_assertions (
    input wire                      clk,
    input wire                      rst,
    input wire                      s_valid,
    input wire                      s_resp_valid,
    input wire                      s_found,
    input wire tlb_pkg::tlb_index_t s_index
);
    import tlb_pkg::*;

    // ------------------------------
    // search response strobe
    // ------------------------------
    resp_low_after_reset: assert property (@(posedge clk) rst |=> !s_resp_valid)
        else $error("s_resp_valid high in the cycle after reset");

    resp_follows_req: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> s_resp_valid == $past(s_valid))
        else $error("s_resp_valid does not follow s_valid by one cycle");

    // miss gives a zero index
    index_zero_on_miss: assert property (@(posedge clk) disable iff (rst)
        !s_found |-> s_index == '0)
        else $error("s_index not zero on a miss");

endmodule

bind tlb_unit tlb_assertions u_assertions (
    .clk         (clk),
    .rst         (rst),
    .s_valid     (s_valid),
    .s_resp_valid(s_resp_valid),
    .s_found     (s_found),
    .s_index     (s_index)
);

`default_nettype wire

//--- test/tlb_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_config.svh"

module tlb_tb;
    import tlb_pkg::*;

    typedef logic [25:0] page_t; // {ppn, plv, mat, d, v}

    localparam int MAX_CYCLES = 4000; // about twice the scripted run

    logic clk = 1'b0;
    logic rst;
    logic s_valid, s_va_bit12;
    vppn_t s_vppn;
    asid_t s_asid;
    logic s_resp_valid, s_found, s_d, s_v;
    tlb_index_t s_index;
    ppn_t s_ppn;
    ps_t s_ps;
    plv_t s_plv;
    mat_t s_mat;
    logic invtlb_valid;
    invtlb_op_t invtlb_op;
    logic we, w_e, w_g, w_d0, w_v0, w_d1, w_v1;
    tlb_index_t w_index, r_index;
    vppn_t w_vppn, r_vppn;
    ps_t w_ps, r_ps;
    asid_t w_asid, r_asid;
    ppn_t w_ppn0, w_ppn1, r_ppn0, r_ppn1;
    plv_t w_plv0, w_plv1, r_plv0, r_plv1;
    mat_t w_mat0, w_mat1, r_mat0, r_mat1;
    logic r_e, r_g, r_d0, r_v0, r_d1, r_v1;
    logic rd_chk; // a read result is expected next cycle

    // shadow table
    logic  sh_e    [`TLB_NUM];
    logic  sh_g    [`TLB_NUM];
    vppn_t sh_vppn [`TLB_NUM];
    ps_t   sh_ps   [`TLB_NUM];
    asid_t sh_asid [`TLB_NUM];
    page_t sh_pg0  [`TLB_NUM];
    page_t sh_pg1  [`TLB_NUM];
    logic  written [`TLB_NUM] = '{default: 1'b0};

    logic s_pend, r_pend, re_full, re_e, re_g;
    logic [36:0] exp_s; // {found, index, ps, page}
    vppn_t re_vppn;
    ps_t re_ps;
    asid_t re_asid;
    page_t re_pg0, re_pg1;
    logic [31:0] lcg_state = 32'hddd5;
    int cycles = 0;
    int checks = 0;
    int errors = 0;

    tlb_unit DUT (.*);

    always #20 clk = ~clk;

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic logic vppn_eq(input tlb_index_t i, input vppn_t vppn);
        if (sh_ps[i] == ps_t'(`TLB_PS_2M)) begin
            return sh_vppn[i][18:9] == vppn[18:9];
        end
        return sh_vppn[i] == vppn;
    endfunction

    function automatic logic [36:0] ref_search(input vppn_t vppn, input logic va12,
                                               input asid_t asid);
        logic odd;
        for (int i = 0; i < `TLB_NUM; i++) begin
            if (sh_e[i] && (sh_g[i] || sh_asid[i] == asid) && vppn_eq(tlb_index_t'(i), vppn)) begin
                odd = (sh_ps[i] == ps_t'(`TLB_PS_2M)) ? vppn[8] : va12;
                return {1'b1, tlb_index_t'(i), sh_ps[i], odd ? sh_pg1[i] : sh_pg0[i]};
            end
        end
        return '0; // miss
    endfunction

    function automatic logic inv_sel(input tlb_index_t i, input invtlb_op_t op,
                                     input vppn_t vppn, input asid_t asid);
        logic am;
        logic vm;
        am = (sh_asid[i] == asid);
        vm = vppn_eq(i, vppn);
        case (op)
            5'd0, 5'd1: return 1'b1;
            5'd2:       return sh_g[i];
            5'd3:       return !sh_g[i];
            5'd4:       return !sh_g[i] && am;
            5'd5:       return !sh_g[i] && am && vm;
            5'd6:       return (sh_g[i] || am) && vm;
            default:    return 1'b0;
        endcase
    endfunction

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (rst) begin
            for (int i = 0; i < `TLB_NUM; i++) begin
                sh_e[i] = 1'b0;
            end
            s_pend = 1'b0;
            r_pend = 1'b0;
        end else begin
            // expectations see the table as it was before this edge
            s_pend = s_valid;
            exp_s = s_valid ? ref_search(s_vppn, s_va_bit12, s_asid) : '0;
            r_pend = rd_chk;
            re_full = written[r_index];
            re_e = sh_e[r_index];
            re_g = sh_g[r_index];
            re_vppn = sh_vppn[r_index];
            re_ps = sh_ps[r_index];
            re_asid = sh_asid[r_index];
            re_pg0 = sh_pg0[r_index];
            re_pg1 = sh_pg1[r_index];
            if (invtlb_valid) begin
                for (int i = 0; i < `TLB_NUM; i++) begin
                    if (inv_sel(tlb_index_t'(i), invtlb_op, s_vppn, s_asid)) sh_e[i] = 1'b0;
                end
            end
            if (we) begin // applied after invalidate
                sh_e[w_index] = w_e;
                sh_g[w_index] = w_g;
                sh_vppn[w_index] = w_vppn;
                sh_ps[w_index] = w_ps;
                sh_asid[w_index] = w_asid;
                sh_pg0[w_index] = {w_ppn0, w_plv0, w_mat0, w_d0, w_v0};
                sh_pg1[w_index] = {w_ppn1, w_plv1, w_mat1, w_d1, w_v1};
                written[w_index] = 1'b1;
            end
        end
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------
    // compare
    // ------------------------------
    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    always @(negedge clk) begin
        if (cycles > 0) begin
            check("s_resp_valid", 32'(s_resp_valid), 32'(s_pend));
            if (s_pend) begin
                check("s_found", 32'(s_found), 32'(exp_s[36]));
                check("s_index", 32'(s_index), 32'(exp_s[35:32]));
                check("s_ps", 32'(s_ps), 32'(exp_s[31:26]));
                check("s_ppn", 32'(s_ppn), 32'(exp_s[25:6]));
                check("s_plv", 32'(s_plv), 32'(exp_s[5:4]));
                check("s_mat", 32'(s_mat), 32'(exp_s[3:2]));
                check("s_d", 32'(s_d), 32'(exp_s[1]));
                check("s_v", 32'(s_v), 32'(exp_s[0]));
            end
            if (r_pend) begin
                check("r_e", 32'(r_e), 32'(re_e));
            end
            if (r_pend && re_full) begin // payload of unwritten entries is unknown
                check("r_g", 32'(r_g), 32'(re_g));
                check("r_vppn", 32'(r_vppn), 32'(re_vppn));
                check("r_ps", 32'(r_ps), 32'(re_ps));
                check("r_asid", 32'(r_asid), 32'(re_asid));
                check("{r_ppn0,r_plv0,r_mat0,r_d0,r_v0}",
                      32'({r_ppn0, r_plv0, r_mat0, r_d0, r_v0}), 32'(re_pg0));
                check("{r_ppn1,r_plv1,r_mat1,r_d1,r_v1}",
                      32'({r_ppn1, r_plv1, r_mat1, r_d1, r_v1}), 32'(re_pg1));
            end
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    function automatic vppn_t pick_vppn(); // few high parts, so entries collide
        logic [31:0] r;
        r = next_rand();
        return {8'h5a, r[1:0], r[2], 6'd0, r[4:3]};
    endfunction

    function automatic asid_t pick_asid();
        logic [31:0] r;
        r = next_rand();
        return asid_t'(r[1:0]);
    endfunction

    function automatic ps_t page_size(input int mode, input logic pick);
        if (mode == 0 || (mode == 2 && !pick)) return ps_t'(`TLB_PS_4K);
        return ps_t'(`TLB_PS_2M);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        we <= 1'b0;
        invtlb_valid <= 1'b0;
        s_valid <= 1'b0;
        rd_chk <= 1'b0;
    endtask

    task automatic write_entry(input tlb_index_t idx, input logic e, input logic g,
                               input ps_t ps, input vppn_t vppn, input asid_t asid);
        logic [31:0] r;
        r = next_rand();
        we <= 1'b1;
        w_index <= idx;
        w_e <= e;
        w_g <= g;
        w_ps <= ps;
        w_vppn <= vppn;
        w_asid <= asid;
        {w_ppn0, w_plv0, w_mat0, w_d0, w_v0} <= r[25:0];
        r = next_rand();
        {w_ppn1, w_plv1, w_mat1, w_d1, w_v1} <= r[25:0];
    endtask

    task automatic search_req(input vppn_t vppn, input logic va12, input asid_t asid);
        s_valid <= 1'b1;
        s_vppn <= vppn;
        s_va_bit12 <= va12;
        s_asid <= asid;
    endtask

    task automatic random_search();
        logic [31:0] r;
        r = next_rand();
        search_req(pick_vppn() ^ {10'd0, r[8:0]} & {10'd0, {9{r[9]}}}, r[10], pick_asid());
    endtask

    // invtlb reuses the search port's vppn and asid
    task automatic invalidate(input invtlb_op_t op, input vppn_t vppn, input asid_t asid);
        invtlb_valid <= 1'b1;
        invtlb_op <= op;
        s_vppn <= vppn;
        s_asid <= asid;
    endtask

    task automatic read_req(input tlb_index_t idx);
        r_index <= idx;
        rd_chk <= 1'b1;
    endtask

    task automatic fill_table(input int mode); // mode 0: 4 KB, 1: 2 MB, 2: mixed
        logic [31:0] r;
        for (int i = 0; i < `TLB_NUM; i++) begin
            r = next_rand();
            next_cycle();
            write_entry(tlb_index_t'(i), 1'b1, r[2:0] == 3'd0, page_size(mode, r[3]),
                        pick_vppn(), pick_asid());
        end
    endtask

    initial begin
        logic [31:0] r;
        rst = 1'b1;
        {s_valid, s_va_bit12, s_vppn, s_asid, invtlb_valid, invtlb_op} = '0;
        {we, w_index, w_e, w_g, w_vppn, w_ps, w_asid} = '0;
        {w_ppn0, w_plv0, w_mat0, w_d0, w_v0, w_ppn1, w_plv1, w_mat1, w_d1, w_v1} = '0;
        {r_index, rd_chk} = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // empty table after reset
        for (int i = 0; i < `TLB_NUM; i++) begin
            next_cycle();
            random_search();
            read_req(tlb_index_t'(i));
        end
        // write then read back
        fill_table(2);
        for (int i = 0; i < `TLB_NUM; i++) begin
            next_cycle();
            read_req(tlb_index_t'(i));
        end
        // 4 KB then 2 MB pages
        for (int mode = 0; mode < 2; mode++) begin
            fill_table(mode);
            repeat (64) begin
                next_cycle();
                random_search();
            end
        end
        // each invtlb op, the last one undefined
        for (int k = 0; k < 8; k++) begin
            fill_table(2);
            next_cycle();
            invalidate((k == 7) ? 5'd13 : invtlb_op_t'(k), pick_vppn(), pick_asid());
            for (int i = 0; i < `TLB_NUM; i++) begin
                next_cycle();
                random_search();
                read_req(tlb_index_t'(i));
            end
        end
        // random mix
        repeat (1500) begin
            r = next_rand();
            next_cycle();
            if (r[0]) random_search();
            if (r[3:1] == 3'd0) begin
                write_entry(tlb_index_t'(r[11:8]), r[12] | r[13], r[16:14] == 3'd0,
                            page_size(2, r[17]), pick_vppn(), pick_asid());
            end
            if (r[7:4] == 4'd0) invalidate(invtlb_op_t'(r[20:18]), pick_vppn(), pick_asid());
            read_req(tlb_index_t'(r[24:21]));
        end
        repeat (3) next_cycle();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verilog
verilog/tlb_pkg.sv
verilog/tlb_entry_array.sv
verilog/tlb_match.sv
verilog/tlb_search_stage.sv
verilog/tlb_unit.sv
test/tlb_assertions.sv
test/tlb_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS := --lint-only --timing --timescale 1ns/1ps
TOP       := tlb_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
